// File: src/busPkg.sv
// APB register map and bus structs for the arena core
// APB3 subset with no wait states, so pready is constant 1
// Only paddr[3:0] is decoded, and offsets are byte addresses
package busPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;   // 39 bits

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;   // 34 bits

    // Keycode register, read and write
    localparam logic [3:0] KEY_ADDR = 4'h0;

    // Player status, read-only
    // X in [8:0], Y in [24:16], dir in [29:28], attackOn in [31]
    localparam logic [3:0] PLAYER_ADDR = 4'h4;

endpackage

// File: src/gamePkg.sv
// Game geometry, keycodes and pixel types for the arena core
// Coordinates are 9 bits and wrap modulo 512
// Sprites are fixed at 16x16, so a sprite address fits in 8 bits
package gamePkg;

    typedef logic [8:0] coordT;

    typedef enum logic [1:0] {
        DOWN  = 2'd0,
        LEFT  = 2'd1,
        UP    = 2'd2,
        RIGHT = 2'd3
    } dirT;

    typedef struct packed {
        coordT x;
        coordT y;
        dirT   dir;
    } playerStateT;   // 20 bits

    typedef struct packed {
        logic       hit;
        logic [7:0] addr;   // Row-major, offX + 16*offY
    } spriteHitT;

    typedef enum logic [1:0] {
        FLOOR  = 2'd0,
        WALL   = 2'd1,
        PLAYER = 2'd2,
        ATTACK = 2'd3
    } layerT;

    typedef struct packed {
        layerT      layer;
        logic [7:0] addr;
    } pixelT;   // 10 bits

    localparam int SPRITE_W = 16;
    localparam int SPRITE_H = 16;
    localparam int ARENA_W  = 320;
    localparam int ARENA_H  = 240;
    localparam int STEP     = 16;   // Pixels per player step
    localparam int MOTION_DIV = 4;  // Frame edges per motion tick

    localparam coordT PLAYER_X0 = 9'd160;
    localparam coordT PLAYER_Y0 = 9'd112;
    localparam dirT   DIR0      = DOWN;

    // USB HID usage codes
    localparam logic [7:0] KEY_SPACE = 8'd44;
    localparam logic [7:0] KEY_W     = 8'd26;
    localparam logic [7:0] KEY_A     = 8'd4;
    localparam logic [7:0] KEY_S     = 8'd22;
    localparam logic [7:0] KEY_D     = 8'd7;

endpackage

// File: src/apbKeyRegs.sv
// APB slave with the keycode register and a read-only player status word
// No wait states; read data and pslverr are combinational in the access cycle
// Unmapped offsets give pslverr, writes to them are ignored and reads return 0
module apbKeyRegs (
    input  logic                 Clk,
    input  logic                 arstN,
    input  busPkg::apbReqT       apbReq,
    output busPkg::apbRspT       apbRsp,
    output logic [7:0]           keycode,
    input  gamePkg::playerStateT player,
    input  logic                 attackOn
);
    import busPkg::*;

    logic        access;
    logic        keySel;
    logic        playerSel;
    logic [31:0] statusWord;

    assign access    = apbReq.psel && apbReq.penable;
    assign keySel    = (apbReq.paddr == KEY_ADDR);
    assign playerSel = (apbReq.paddr == PLAYER_ADDR);

    // Status word layout as in the register map
    assign statusWord = {attackOn, 1'b0, player.dir, 3'b000, player.y,
                         7'b0000000, player.x};

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            keycode <= '0;
        end else if (access && apbReq.pwrite && keySel) begin
            keycode <= apbReq.pwdata[7:0];
        end
    end

    always_comb begin
        apbRsp.pready  = 1'b1;
        apbRsp.pslverr = access && !(keySel || playerSel);
        apbRsp.prdata  = '0;
        if (access && !apbReq.pwrite) begin
            if (keySel) begin
                apbRsp.prdata = {24'd0, keycode};
            end else if (playerSel) begin
                apbRsp.prdata = statusWord;
            end
        end
    end

endmodule

// File: src/frameTicker.sv
// Turns the frame-sync input into a motion tick on every MOTION_DIV-th rising edge
// frameSync is assumed to be slow and held for at least two clock cycles
// Edge pulse one cycle after sampling, tick one cycle after that
module frameTicker (
    input  logic Clk,
    input  logic arstN,
    input  logic frameSync,
    output logic motionTick
);
    import gamePkg::*;

    localparam int CNT_W = $clog2(MOTION_DIV);

    logic             syncQ;
    logic             syncQd;
    logic             edgePulse;
    logic [CNT_W-1:0] edgeCnt;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            syncQ      <= 1'b0;
            syncQd     <= 1'b0;
            edgePulse  <= 1'b0;
            edgeCnt    <= '0;
            motionTick <= 1'b0;
        end else begin
            syncQ      <= frameSync;
            syncQd     <= syncQ;
            edgePulse  <= syncQ && !syncQd;   // Rising edge seen
            motionTick <= edgePulse && (edgeCnt == CNT_W'(MOTION_DIV - 1));
            if (edgePulse) begin
                edgeCnt <= (edgeCnt == CNT_W'(MOTION_DIV - 1)) ? '0 : edgeCnt + 1'b1;
            end
        end
    end

endmodule

// File: src/playerMotion.sv
// Player position and facing, stepped on each motion tick
// WASD keys turn and move the player by STEP pixels
// Position is clamped so the whole sprite stays inside the arena
module playerMotion (
    input  logic                 Clk,
    input  logic                 arstN,
    input  logic                 motionTick,
    input  logic [7:0]           keycode,
    output gamePkg::playerStateT player
);
    import gamePkg::*;

    localparam int X_MAX = ARENA_W - SPRITE_W;
    localparam int Y_MAX = ARENA_H - SPRITE_H;

    playerStateT nextState;
    logic [9:0]  xSum;   // Wide so the clamp test cannot wrap
    logic [9:0]  ySum;

    assign xSum = {1'b0, player.x} + 10'(STEP);
    assign ySum = {1'b0, player.y} + 10'(STEP);

    always_comb begin
        nextState = player;
        case (keycode)
            KEY_W: begin
                nextState.dir = UP;
                nextState.y   = (player.y < coordT'(STEP)) ? '0 : player.y - coordT'(STEP);
            end
            KEY_A: begin
                nextState.dir = LEFT;
                nextState.x   = (player.x < coordT'(STEP)) ? '0 : player.x - coordT'(STEP);
            end
            KEY_S: begin
                nextState.dir = DOWN;
                nextState.y   = (ySum > 10'(Y_MAX)) ? coordT'(Y_MAX) : coordT'(ySum);
            end
            KEY_D: begin
                nextState.dir = RIGHT;
                nextState.x   = (xSum > 10'(X_MAX)) ? coordT'(X_MAX) : coordT'(xSum);
            end
            default: ;   // Any other key holds still
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            player.x   <= PLAYER_X0;
            player.y   <= PLAYER_Y0;
            player.dir <= DIR0;
        end else if (motionTick) begin
            player <= nextState;
        end
    end

endmodule

// File: src/spriteWindow.sv
// Combinational hit test of one SPRITE_W x SPRITE_H sprite
// Window bounds are compared unwrapped, so a sprite near 511 does not reach 0
// Address is row-major inside the sprite, and all zero on a miss
module spriteWindow (
    input  gamePkg::coordT     originX,
    input  gamePkg::coordT     originY,
    input  logic               enable,
    input  gamePkg::coordT     pixelX,
    input  gamePkg::coordT     pixelY,
    output gamePkg::spriteHitT hit
);
    import gamePkg::*;

    logic  inX;
    logic  inY;
    coordT offX;
    coordT offY;

    assign inX = (pixelX >= originX) && ({1'b0, pixelX} < {1'b0, originX} + 10'(SPRITE_W));
    assign inY = (pixelY >= originY) && ({1'b0, pixelY} < {1'b0, originY} + 10'(SPRITE_H));

    assign offX = pixelX - originX;
    assign offY = pixelY - originY;

    always_comb begin
        hit = '0;
        if (enable && inX && inY) begin
            hit.hit  = 1'b1;
            hit.addr = 8'(offY * SPRITE_W + offX);
        end
    end

endmodule

// File: src/attackSprite.sv
// Attack sprite shown one sprite width in front of the player
// Visible while the space key is held, one cycle behind the key register
// Origin wraps modulo 512, so an attack off the left or top edge lands near 496
module attackSprite (
    input  logic                 Clk,
    input  logic                 arstN,
    input  logic [7:0]           keycode,
    input  gamePkg::playerStateT player,
    input  gamePkg::coordT       pixelX,
    input  gamePkg::coordT       pixelY,
    output logic                 attackOn,
    output gamePkg::spriteHitT   hit
);
    import gamePkg::*;

    coordT originX;
    coordT originY;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            attackOn <= 1'b0;
        end else begin
            attackOn <= (keycode == KEY_SPACE);
        end
    end

    // Shift the origin toward the facing side
    always_comb begin
        originX = player.x;
        originY = player.y;
        case (player.dir)
            DOWN:    originY = player.y + coordT'(SPRITE_H);
            LEFT:    originX = player.x - coordT'(SPRITE_W);
            UP:      originY = player.y - coordT'(SPRITE_H);
            RIGHT:   originX = player.x + coordT'(SPRITE_W);
            default: ;
        endcase
    end

    spriteWindow uAttackWin (
        .originX (originX),
        .originY (originY),
        .enable  (attackOn),
        .pixelX  (pixelX),
        .pixelY  (pixelY),
        .hit     (hit)
    );

endmodule

// File: src/pixelMixer.sv
// Layer priority and output register for one pixel per cycle
// Priority is attack, player, wall, floor
// Anything outside the arena counts as wall
module pixelMixer (
    input  logic               Clk,
    input  logic               arstN,
    input  gamePkg::coordT     pixelX,
    input  gamePkg::coordT     pixelY,
    input  gamePkg::spriteHitT attackHit,
    input  gamePkg::spriteHitT playerHit,
    output gamePkg::pixelT     pixel
);
    import gamePkg::*;

    logic  isWall;
    pixelT nextPixel;

    assign isWall = (pixelX == '0) || (pixelX >= coordT'(ARENA_W - 1)) ||
                    (pixelY == '0) || (pixelY >= coordT'(ARENA_H - 1));

    always_comb begin
        nextPixel = '{layer: FLOOR, addr: 8'd0};
        if (attackHit.hit) begin
            nextPixel = '{layer: ATTACK, addr: attackHit.addr};
        end else if (playerHit.hit) begin
            nextPixel = '{layer: PLAYER, addr: playerHit.addr};
        end else if (isWall) begin
            nextPixel.layer = WALL;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pixel <= '{layer: FLOOR, addr: 8'd0};
        end else begin
            pixel <= nextPixel;
        end
    end

endmodule

// File: src/arenaTop.sv
// Arena game core: APB key register, frame pacing, player, attack and pixel layers
// Pixel result appears one cycle after the coordinate, one coordinate per cycle
module arenaTop (
    input  logic             Clk,
    input  logic             arstN,
    input  busPkg::apbReqT   apbReq,
    output busPkg::apbRspT   apbRsp,
    input  logic             frameSync,
    input  gamePkg::coordT   pixelX,
    input  gamePkg::coordT   pixelY,
    output gamePkg::pixelT   pixel
);
    import gamePkg::*;

    logic [7:0]  keycode;
    logic        motionTick;
    logic        attackOn;
    playerStateT player;
    spriteHitT   attackHit;
    spriteHitT   playerHit;

    apbKeyRegs uKeyRegs (
        .Clk      (Clk),
        .arstN    (arstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .keycode  (keycode),
        .player   (player),
        .attackOn (attackOn)
    );

    frameTicker uTicker (
        .Clk        (Clk),
        .arstN      (arstN),
        .frameSync  (frameSync),
        .motionTick (motionTick)
    );

    playerMotion uPlayer (
        .Clk        (Clk),
        .arstN      (arstN),
        .motionTick (motionTick),
        .keycode    (keycode),
        .player     (player)
    );

    spriteWindow uPlayerWin (
        .originX (player.x),
        .originY (player.y),
        .enable  (1'b1),   // Player is always drawn
        .pixelX  (pixelX),
        .pixelY  (pixelY),
        .hit     (playerHit)
    );

    attackSprite uAttack (
        .Clk      (Clk),
        .arstN    (arstN),
        .keycode  (keycode),
        .player   (player),
        .pixelX   (pixelX),
        .pixelY   (pixelY),
        .attackOn (attackOn),
        .hit      (attackHit)
    );

    pixelMixer uMixer (
        .Clk       (Clk),
        .arstN     (arstN),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .attackHit (attackHit),
        .playerHit (playerHit),
        .pixel     (pixel)
    );

endmodule

// File: tb/arenaTb.sv
// Testbench for arenaTop: APB key register, frame pacing, player and attack pixels
// Model player state advances on every MOTION_DIV-th frameSync pulse from reset
// Pixel results are checked one cycle after each coordinate, on the falling edge
module arenaTb;
    timeunit 1ns;
    timeprecision 100ps;
    import busPkg::*;
    import gamePkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYC  = 10;
    localparam int PULSE_CYC  = 10;   // Cycles per frameSync pulse
    localparam int N_PULSES   = 112;
    localparam int REGION     = 48;   // Side of the scan around the player
    localparam int HALF_SCAN  = 1500;
    localparam int WATCHDOG_NS = (RESET_CYC + N_PULSES * PULSE_CYC + 2 * REGION * REGION
                                  + 2 * HALF_SCAN + 1000) * CLK_PERIOD;

    logic        Clk = 1'b0;
    logic        arstN;
    apbReqT      apbReq;
    apbRspT      apbRsp;
    logic        frameSync;
    coordT       pixelX;
    coordT       pixelY;
    pixelT       pixel;

    playerStateT modelPlayer;
    logic [7:0]  modelKey;
    logic        modelAtk;
    int          pulseCount;
    logic [31:0] rngState;
    pixelT       expCur;
    pixelT       expD;
    logic        expValid;
    logic        validD;
    int          errCount;
    int          checkCount;

    arenaTop uut (
        .Clk       (Clk),
        .arstN     (arstN),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .frameSync (frameSync),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .pixel     (pixel)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    function automatic logic [31:0] rand32();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic coordT wrapCoord(input int v);
        return coordT'((v + 1024) % 512);
    endfunction

    // One motion step with clamping to the arena
    function automatic playerStateT stepPlayer(input playerStateT st, input logic [7:0] key);
        int          x;
        int          y;
        playerStateT n;
        x = int'(st.x);
        y = int'(st.y);
        n = st;
        case (key)
            KEY_W: begin
                n.dir = UP;
                y = (y - STEP < 0) ? 0 : y - STEP;
            end
            KEY_A: begin
                n.dir = LEFT;
                x = (x - STEP < 0) ? 0 : x - STEP;
            end
            KEY_S: begin
                n.dir = DOWN;
                y = (y + STEP > ARENA_H - SPRITE_H) ? ARENA_H - SPRITE_H : y + STEP;
            end
            KEY_D: begin
                n.dir = RIGHT;
                x = (x + STEP > ARENA_W - SPRITE_W) ? ARENA_W - SPRITE_W : x + STEP;
            end
            default: ;
        endcase
        n.x = coordT'(x);
        n.y = coordT'(y);
        return n;
    endfunction

    function automatic logic [31:0] statusOf(input playerStateT st, input logic atk);
        return 32'(st.x) | (32'(st.y) << 16) | (32'(st.dir) << 28) | (32'(atk) << 31);
    endfunction

    // Expected layer and address of one pixel
    function automatic pixelT refPixel(input playerStateT st, input logic atk,
                                       input int px, input int py);
        int    plx;
        int    ply;
        int    ax;
        int    ay;
        pixelT r;
        plx = int'(st.x);
        ply = int'(st.y);
        ax  = plx;
        ay  = ply;
        case (st.dir)
            DOWN:    ay = ply + SPRITE_H;
            LEFT:    ax = plx - SPRITE_W;
            UP:      ay = ply - SPRITE_H;
            default: ax = plx + SPRITE_W;
        endcase
        ax = int'(wrapCoord(ax));
        ay = int'(wrapCoord(ay));
        r.layer = FLOOR;
        r.addr  = 8'd0;
        if (atk && px >= ax && px < ax + SPRITE_W && py >= ay && py < ay + SPRITE_H) begin
            r.layer = ATTACK;
            r.addr  = 8'((py - ay) * SPRITE_W + (px - ax));
        end else if (px >= plx && px < plx + SPRITE_W && py >= ply && py < ply + SPRITE_H) begin
            r.layer = PLAYER;
            r.addr  = 8'((py - ply) * SPRITE_W + (px - plx));
        end else if (px == 0 || px >= ARENA_W - 1 || py == 0 || py >= ARENA_H - 1) begin
            r.layer = WALL;   // Border or outside the arena
        end
        return r;
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge Clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge Clk);
        apbReq.penable <= 1'b1;
        @(negedge Clk);
        err = apbRsp.pslverr;
        checkEq(32'(apbRsp.pready), 32'd1, "pready in write access");
        @(posedge Clk);   // Register takes the data here
        apbReq <= '0;
        if (addr == KEY_ADDR) begin
            modelKey = data[7:0];
            modelAtk = (modelKey == KEY_SPACE);
        end
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(posedge Clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge Clk);
        apbReq.penable <= 1'b1;
        @(negedge Clk);
        data = apbRsp.prdata;
        err  = apbRsp.pslverr;
        checkEq(32'(apbRsp.pready), 32'd1, "pready in read access");
        @(posedge Clk);
        apbReq <= '0;
    endtask

    // Long enough for the synchronizer, divider and state update to settle
    task automatic motionPulse();
        @(posedge Clk);
        frameSync <= 1'b1;
        repeat (PULSE_CYC / 2) @(posedge Clk);
        frameSync <= 1'b0;
        repeat (PULSE_CYC / 2 - 1) @(posedge Clk);
        pulseCount++;
        if (pulseCount % MOTION_DIV == 0) begin
            modelPlayer = stepPlayer(modelPlayer, modelKey);
        end
    endtask

    task automatic stepOnce();
        repeat (MOTION_DIV) motionPulse();
    endtask

    task automatic driveCoord(input int x, input int y);
        @(posedge Clk);
        pixelX   <= coordT'(x);
        pixelY   <= coordT'(y);
        expCur   <= refPixel(modelPlayer, modelAtk, x, y);
        expValid <= 1'b1;
    endtask

    task automatic drainScan();
        @(posedge Clk);
        expValid <= 1'b0;
        @(posedge Clk);
    endtask

    task automatic scanRegion();
        int x0;
        int y0;
        x0 = int'(modelPlayer.x) - SPRITE_W;
        y0 = int'(modelPlayer.y) - SPRITE_H;
        for (int dy = 0; dy < REGION; dy++) begin
            for (int dx = 0; dx < REGION; dx++) begin
                driveCoord(int'(wrapCoord(x0 + dx)), int'(wrapCoord(y0 + dy)));
            end
        end
        drainScan();
    endtask

    // Half the points land near the player so the sprites get hit often
    task automatic randomScan(input int n);
        logic [31:0] r;
        int          x;
        int          y;
        repeat (n) begin
            r = rand32();
            if (r[31]) begin
                x = int'(modelPlayer.x) - 24 + int'(rand32() >> 26);
                y = int'(modelPlayer.y) - 24 + int'(rand32() >> 26);
            end else begin
                x = int'(rand32() >> 23);
                y = int'(rand32() >> 23);
            end
            driveCoord(int'(wrapCoord(x)), int'(wrapCoord(y)));
        end
        drainScan();
    endtask

    // Expected pixel lags the coordinate by one register stage
    always @(posedge Clk) begin
        expD   <= expCur;
        validD <= expValid;
    end

    always @(negedge Clk) begin
        if (validD) begin
            checkEq(32'(pixel), 32'(expD), "pixel layer and address");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] r;
        logic [7:0]  key;
        arstN      = 1'b0;
        apbReq     = '0;
        frameSync  = 1'b0;
        pixelX     = '0;
        pixelY     = '0;
        expCur     = '0;
        expValid   = 1'b0;
        errCount   = 0;
        checkCount = 0;
        pulseCount = 0;
        rngState   = 32'h6d9d;
        modelKey   = 8'd0;
        modelAtk   = 1'b0;
        modelPlayer.x   = PLAYER_X0;
        modelPlayer.y   = PLAYER_Y0;
        modelPlayer.dir = DIR0;
        repeat (RESET_CYC) @(posedge Clk);
        arstN <= 1'b1;

        // Register port
        apbRead(PLAYER_ADDR, rd, err);
        checkEq(rd, statusOf(modelPlayer, modelAtk), "status after reset");
        checkEq(32'(err), 32'd0, "pslverr on status read");
        apbWrite(KEY_ADDR, 32'h5a, err);
        apbRead(KEY_ADDR, rd, err);
        checkEq(rd, 32'h5a, "keycode read back");
        apbWrite(4'h8, 32'h2c, err);
        checkEq(32'(err), 32'd1, "pslverr on write to offset 8");
        apbRead(4'h8, rd, err);
        checkEq(32'(err), 32'd1, "pslverr on read of offset 8");
        checkEq(rd, 32'd0, "read data of offset 8");
        apbRead(KEY_ADDR, rd, err);
        checkEq(rd, 32'h5a, "keycode after unmapped write");

        // Pacing, one step per four frame pulses
        apbWrite(KEY_ADDR, 32'(KEY_D), err);
        repeat (2 * MOTION_DIV) begin
            motionPulse();
            apbRead(PLAYER_ADDR, rd, err);
            checkEq(rd, statusOf(modelPlayer, modelAtk), "status while pacing");
        end
        checkEq(32'(rd[8:0]), 32'(PLAYER_X0) + 32'(2 * STEP), "X after eight pulses");

        // Attack sprite with a random facing
        r = rand32();
        case (r[31:30])
            2'd0:    key = KEY_W;
            2'd1:    key = KEY_A;
            2'd2:    key = KEY_S;
            default: key = KEY_D;
        endcase
        apbWrite(KEY_ADDR, 32'(key), err);
        stepOnce();
        apbWrite(KEY_ADDR, 32'(KEY_SPACE), err);
        apbRead(PLAYER_ADDR, rd, err);
        checkEq(rd, statusOf(modelPlayer, modelAtk), "status with attack on");
        scanRegion();
        apbWrite(KEY_ADDR, 32'd0, err);
        scanRegion();

        // Clamping at the top and left edges
        apbWrite(KEY_ADDR, 32'(KEY_W), err);
        repeat (10) stepOnce();
        apbRead(PLAYER_ADDR, rd, err);
        checkEq(rd, statusOf(modelPlayer, modelAtk), "status after W steps");
        checkEq(32'(rd[24:16]), 32'd0, "Y clamped at top");
        checkEq(32'(rd[29:28]), 32'(UP), "facing after W");
        apbWrite(KEY_ADDR, 32'(KEY_A), err);
        repeat (14) stepOnce();
        apbRead(PLAYER_ADDR, rd, err);
        checkEq(rd, statusOf(modelPlayer, modelAtk), "status after A steps");
        checkEq(32'(rd[8:0]), 32'd0, "X clamped at left");
        checkEq(32'(rd[29:28]), 32'(LEFT), "facing after A");

        // Random scan, attack wrapped into the wall area
        apbWrite(KEY_ADDR, 32'(KEY_SPACE), err);
        randomScan(HALF_SCAN);
        apbWrite(KEY_ADDR, 32'(KEY_W), err);
        stepOnce();
        apbWrite(KEY_ADDR, 32'(KEY_SPACE), err);
        randomScan(HALF_SCAN);

        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
src/busPkg.sv
src/gamePkg.sv
src/apbKeyRegs.sv
src/frameTicker.sv
src/playerMotion.sv
src/spriteWindow.sv
src/attackSprite.sv
src/pixelMixer.sv
src/arenaTop.sv
tb/arenaTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the arena core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module arenaTb --Mdir obj_dir -o arenaSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/arenaSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    echo "Testbench reported a failure"
    exit 1
fi
exit 0
